// File: logic/matrix_settings.svh
`ifndef MATRIX_SETTINGS_SVH
`define MATRIX_SETTINGS_SVH

// --------------------------------------------------
// Panel geometry
// --------------------------------------------------
`define MATRIX_COLUMNS      16
`define MATRIX_BANKS        4
// Each group drives an a row and a b row
`define ROW_GROUPS          4

// Brightness depth and PWM phases 0 .. PWM_PHASES-1
`define PIXEL_BITS          4
`define PWM_PHASES          15

// --------------------------------------------------
// Host bus and scan pacing
// --------------------------------------------------
`define BUS_ADDR_BITS       8
`define BUS_DATA_BITS       32
`define SCAN_STEP_CYCLES    2
// Address bit that selects the lane limit registers
`define LIMIT_REGION_BIT    7

`endif

// File: logic/matrix_pkg.sv
`include "matrix_settings.svh"

package matrix_pkg;

    // --------------------------------------------------
    // Plain vectors
    // --------------------------------------------------
    typedef logic [`PIXEL_BITS-1:0]                     pixel_t;
    typedef logic [$clog2(`MATRIX_COLUMNS)-1:0]         column_t;
    typedef logic [$clog2(`MATRIX_BANKS)-1:0]           bank_t;
    typedef logic [$clog2(`PWM_PHASES)-1:0]             phase_t;
    // Byte g is lane g, low nibble row a, high nibble row b
    typedef logic [2*`ROW_GROUPS*`PIXEL_BITS-1:0]       frame_word_t;
    typedef logic [`BUS_ADDR_BITS-1:0]                  bus_addr_t;
    typedef logic [`BUS_DATA_BITS-1:0]                  bus_data_t;

    // --------------------------------------------------
    // Bundles
    // --------------------------------------------------
    typedef struct packed {
        logic      wr_stb;
        logic      rd_stb;
        bus_addr_t addr;
        bus_data_t wdata;
    } host_req_t;

    typedef struct packed {
        logic    valid;
        column_t column;
        bank_t   bank;
        phase_t  phase;
    } scan_tag_t;

    typedef struct packed {
        scan_tag_t   tag;
        frame_word_t word;
    } lane_feed_t;

    // Beat pacing FSM
    typedef enum logic [1:0] {
        SEQ_START,
        SEQ_ISSUE,
        SEQ_WAIT
    } seq_state_t;

endpackage

// File: logic/scan_sequencer.sv
`timescale 1ns/10ps
`include "matrix_settings.svh"

module scan_sequencer import matrix_pkg::*; (
    input  logic      clk_24mhz,
    input  logic      rst_i,
    output scan_tag_t scan_o
);

    localparam int WAIT_BITS = $clog2(`SCAN_STEP_CYCLES);

    seq_state_t           state;
    logic [WAIT_BITS-1:0] wait_cnt;
    column_t              column;
    bank_t                bank;
    phase_t               phase;

    // --------------------------------------------------
    // Beat pacing and scan position
    // --------------------------------------------------
    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            state    <= SEQ_START;
            wait_cnt <= '0;
            column   <= '0;
            bank     <= '0;
            phase    <= '0;
            scan_o   <= '0;
        end else begin
            case (state)
                // Start only differs in being the state left by reset
                SEQ_START, SEQ_ISSUE: begin
                    scan_o.valid  <= 1'b1;
                    scan_o.column <= column;
                    scan_o.bank   <= bank;
                    scan_o.phase  <= phase;
                    wait_cnt      <= '0;
                    state         <= SEQ_WAIT;

                    // Column innermost, then bank, then phase
                    if (column == column_t'(`MATRIX_COLUMNS - 1)) begin
                        column <= '0;
                        if (bank == bank_t'(`MATRIX_BANKS - 1)) begin
                            bank <= '0;
                            if (phase == phase_t'(`PWM_PHASES - 1)) begin
                                phase <= '0;
                            end else begin
                                phase <= phase + 1'b1;
                            end
                        end else begin
                            bank <= bank + 1'b1;
                        end
                    end else begin
                        column <= column + 1'b1;
                    end
                end

                SEQ_WAIT: begin
                    scan_o.valid <= 1'b0;
                    // Idle cycles between two beats
                    if (wait_cnt == WAIT_BITS'(`SCAN_STEP_CYCLES - 2)) begin
                        state <= SEQ_ISSUE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end

                default: begin
                    scan_o.valid <= 1'b0;
                    state        <= SEQ_START;
                end
            endcase
        end
    end

endmodule

// File: logic/frame_store.sv
`timescale 1ns/10ps
`include "matrix_settings.svh"

module frame_store import matrix_pkg::*; (
    input  logic                   clk_24mhz,
    input  logic                   rst_i,
    input  host_req_t              host_req_i,
    input  scan_tag_t              scan_i,
    output logic                   rd_valid_o,
    output bus_data_t              rd_data_o,
    output lane_feed_t             feed_o,
    output logic [`ROW_GROUPS-1:0] limit_wr_o,
    output pixel_t                 limit_o
);

    localparam int FRAME_WORDS = `MATRIX_COLUMNS * `MATRIX_BANKS;
    localparam int INDEX_BITS  = $clog2(FRAME_WORDS);
    localparam int LANE_BITS   = $clog2(`ROW_GROUPS);

    frame_word_t           mem [FRAME_WORDS];
    logic [INDEX_BITS-1:0] host_index;
    logic [INDEX_BITS-1:0] scan_index;
    logic [LANE_BITS-1:0]  lane_sel;
    logic                  limit_region;
    scan_tag_t             feed_tag_q;
    frame_word_t           feed_word_q;

    // Blank panel at power-up
    initial begin
        for (int i = 0; i < FRAME_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    // Frame word address is bank * 16 + column
    assign host_index   = host_req_i.addr[INDEX_BITS-1:0];
    assign scan_index   = {scan_i.bank, scan_i.column};
    assign lane_sel     = host_req_i.addr[LANE_BITS-1:0];
    assign limit_region = host_req_i.addr[`LIMIT_REGION_BIT];

    // Host write port and both read ports
    always_ff @(posedge clk_24mhz) begin
        if (host_req_i.wr_stb && !limit_region) begin
            mem[host_index] <= host_req_i.wdata;
        end
        feed_word_q <= mem[scan_index];
        // Limit registers are write only
        rd_data_o   <= limit_region ? '0 : mem[host_index];
    end

    // --------------------------------------------------
    // Control flops
    // --------------------------------------------------
    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            rd_valid_o <= 1'b0;
            feed_tag_q <= '0;
            limit_wr_o <= '0;
        end else begin
            rd_valid_o <= host_req_i.rd_stb;
            feed_tag_q <= scan_i;
            limit_wr_o <= '0;
            if (host_req_i.wr_stb && limit_region) begin
                limit_wr_o[lane_sel] <= 1'b1;
            end
        end
    end

    // Limit value rides with the strobe
    always_ff @(posedge clk_24mhz) begin
        if (host_req_i.wr_stb && limit_region) begin
            limit_o <= host_req_i.wdata[`PIXEL_BITS-1:0];
        end
    end

    assign feed_o = {feed_tag_q, feed_word_q};

endmodule

// File: logic/row_pwm_lane.sv
`timescale 1ns/10ps
`include "matrix_settings.svh"

module row_pwm_lane import matrix_pkg::*; (
    input  logic                     clk_24mhz,
    input  logic                     rst_i,
    input  logic                     limit_wr_i,
    input  pixel_t                   limit_i,
    input  logic [2*`PIXEL_BITS-1:0] pixels_i,
    input  phase_t                   phase_i,
    output logic [1:0]               row_bits_o
);

    pixel_t limit_q;
    pixel_t pixel_a;
    pixel_t pixel_b;
    logic   phase_allowed;

    // Low nibble row a, high nibble row b
    assign pixel_a = pixels_i[`PIXEL_BITS-1:0];
    assign pixel_b = pixels_i[2*`PIXEL_BITS-1:`PIXEL_BITS];

    // Phases at or above the limit stay dark
    assign phase_allowed = phase_i < limit_q;

    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            limit_q <= '1;
        end else if (limit_wr_i) begin
            limit_q <= limit_i;
        end
    end

    // Row lit while brightness exceeds the phase
    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            row_bits_o <= '0;
        end else begin
            row_bits_o[0] <= (pixel_a > phase_i) && phase_allowed;
            row_bits_o[1] <= (pixel_b > phase_i) && phase_allowed;
        end
    end

endmodule

// File: logic/row_latch.sv
`timescale 1ns/10ps
`include "matrix_settings.svh"

module row_latch import matrix_pkg::*; (
    input  logic                       clk_24mhz,
    input  logic                       rst_i,
    input  scan_tag_t                  feed_tag_i,
    input  logic [2*`ROW_GROUPS-1:0]   lane_bits_i,
    output logic [2*`ROW_GROUPS-1:0]   row_data_o,
    output logic                       col_first_o,
    output logic                       col_advance_o,
    output logic                       rclk_o,
    output logic                       row_oe_n_o,
    output logic [`MATRIX_BANKS-1:0]   latch_row_bank_o,
    output logic                       frame_complete_o
);

    scan_tag_t tag_q;
    logic      started_q;
    logic      last_col_q;
    logic      first_col;
    logic      last_col;
    logic      last_beat;

    // Tag delayed to sit beside the lane bits
    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            tag_q <= '0;
        end else begin
            tag_q <= feed_tag_i;
        end
    end

    // --------------------------------------------------
    // Beat decode
    // --------------------------------------------------
    assign first_col = tag_q.valid && (tag_q.column == '0);
    assign last_col  = tag_q.valid && (tag_q.column == column_t'(`MATRIX_COLUMNS - 1));
    assign last_beat = last_col && (tag_q.bank == bank_t'(`MATRIX_BANKS - 1))
                       && (tag_q.phase == phase_t'(`PWM_PHASES - 1));

    // --------------------------------------------------
    // Panel pins
    // --------------------------------------------------
    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            started_q        <= 1'b0;
            last_col_q       <= 1'b0;
            row_data_o       <= '0;
            col_first_o      <= 1'b0;
            col_advance_o    <= 1'b0;
            rclk_o           <= 1'b0;
            row_oe_n_o       <= 1'b1;
            latch_row_bank_o <= '0;
            frame_complete_o <= 1'b0;
        end else begin
            started_q     <= started_q | tag_q.valid;
            col_advance_o <= tag_q.valid;
            col_first_o   <= first_col;
            // Register clock trails the last column by one cycle
            last_col_q    <= last_col;
            rclk_o        <= last_col_q;
            // Outputs blanked while the bank select changes
            row_oe_n_o       <= ~(started_q | tag_q.valid) | first_col;
            frame_complete_o <= last_beat;
            if (tag_q.valid) begin
                row_data_o <= lane_bits_i;
            end
            if (first_col) begin
                latch_row_bank_o <= `MATRIX_BANKS'(1) << tag_q.bank;
            end
        end
    end

endmodule

// File: logic/led_matrix_top.sv
`timescale 1ns/10ps
`include "matrix_settings.svh"

module led_matrix_top import matrix_pkg::*; (
    input  logic                       clk_24mhz,
    input  logic                       rst_i,

    // Host register port
    input  host_req_t                  host_req_i,
    output logic                       rd_valid_o,
    output bus_data_t                  rd_data_o,

    // Panel pins
    output logic [2*`ROW_GROUPS-1:0]   row_data_o,
    output logic                       col_first_o,
    output logic                       col_advance_o,
    output logic                       rclk_o,
    output logic                       row_oe_n_o,
    output logic [`MATRIX_BANKS-1:0]   latch_row_bank_o,
    output logic                       frame_complete_o
);

    scan_tag_t                   scan;
    lane_feed_t                  feed;
    logic [`ROW_GROUPS-1:0]      limit_wr;
    pixel_t                      limit;
    logic [2*`ROW_GROUPS-1:0]    lane_bits;

    // --------------------------------------------------
    // Scan pipe
    // --------------------------------------------------
    scan_sequencer u_scan_sequencer (
        .clk_24mhz  ( clk_24mhz ),
        .rst_i      ( rst_i     ),
        .scan_o     ( scan      )
    );

    frame_store u_frame_store (
        .clk_24mhz  ( clk_24mhz  ),
        .rst_i      ( rst_i      ),
        .host_req_i ( host_req_i ),
        .scan_i     ( scan       ),
        .rd_valid_o ( rd_valid_o ),
        .rd_data_o  ( rd_data_o  ),
        .feed_o     ( feed       ),
        .limit_wr_o ( limit_wr   ),
        .limit_o    ( limit      )
    );

    // One lane per row group, byte g of the frame word
    for (genvar g = 0; g < `ROW_GROUPS; g++) begin : g_lane
        row_pwm_lane u_row_pwm_lane (
            .clk_24mhz  ( clk_24mhz                                   ),
            .rst_i      ( rst_i                                       ),
            .limit_wr_i ( limit_wr[g]                                 ),
            .limit_i    ( limit                                       ),
            .pixels_i   ( feed.word[g*2*`PIXEL_BITS +: 2*`PIXEL_BITS] ),
            .phase_i    ( feed.tag.phase                              ),
            .row_bits_o ( lane_bits[g*2 +: 2]                         )
        );
    end

    row_latch u_row_latch (
        .clk_24mhz        ( clk_24mhz        ),
        .rst_i            ( rst_i            ),
        .feed_tag_i       ( feed.tag         ),
        .lane_bits_i      ( lane_bits        ),
        .row_data_o       ( row_data_o       ),
        .col_first_o      ( col_first_o      ),
        .col_advance_o    ( col_advance_o    ),
        .rclk_o           ( rclk_o           ),
        .row_oe_n_o       ( row_oe_n_o       ),
        .latch_row_bank_o ( latch_row_bank_o ),
        .frame_complete_o ( frame_complete_o )
    );

endmodule

// File: tests/tb_led_matrix.sv
`timescale 1ns/10ps
`include "matrix_settings.svh"

module tb_led_matrix import matrix_pkg::*; ();

    localparam int CLK_PERIOD     = 40;
    localparam int FRAME_WORDS    = `MATRIX_COLUMNS * `MATRIX_BANKS;
    localparam int FRAME_BEATS    = FRAME_WORDS * `PWM_PHASES;
    localparam int FRAME_CYCLES   = FRAME_BEATS * `SCAN_STEP_CYCLES;
    localparam int HOST_CYCLES    = 400;
    // Four scanned frames, the host traffic and one spare frame
    localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + HOST_CYCLES;
    localparam int SKIP_BEATS     = `MATRIX_COLUMNS;
    localparam int LIMIT_BASE     = 1 << `LIMIT_REGION_BIT;

    logic                     clk_24mhz;
    logic                     rst_i;
    host_req_t                host_req_i;
    logic                     rd_valid_o;
    bus_data_t                rd_data_o;
    logic [2*`ROW_GROUPS-1:0] row_data_o;
    logic                     col_first_o;
    logic                     col_advance_o;
    logic                     rclk_o;
    logic                     row_oe_n_o;
    logic [`MATRIX_BANKS-1:0] latch_row_bank_o;
    logic                     frame_complete_o;

    // Shadow model of the host writes
    bus_data_t shadow_frame [FRAME_WORDS];
    pixel_t    lane_limit [`ROW_GROUPS];

    logic started = 1'b0;
    logic rclk_due = 1'b0;
    int   beat_cnt = 0;
    int   skip_beats = 0;
    int   checked_beats = 0;
    int   dark_checks = 0;
    int   idle_checks = 0;
    int   frames_seen = 0;
    int   cycles = 0;
    int   errors = 0;
    int   tests_run = 0;
    int   tests_passed = 0;

    led_matrix_top u_led_matrix_top (
        .clk_24mhz        ( clk_24mhz        ),
        .rst_i            ( rst_i            ),
        .host_req_i       ( host_req_i       ),
        .rd_valid_o       ( rd_valid_o       ),
        .rd_data_o        ( rd_data_o        ),
        .row_data_o       ( row_data_o       ),
        .col_first_o      ( col_first_o      ),
        .col_advance_o    ( col_advance_o    ),
        .rclk_o           ( rclk_o           ),
        .row_oe_n_o       ( row_oe_n_o       ),
        .latch_row_bank_o ( latch_row_bank_o ),
        .frame_complete_o ( frame_complete_o )
    );

    initial begin
        clk_24mhz = 1'b0;
        forever #(CLK_PERIOD / 2) clk_24mhz = ~clk_24mhz;
    end

    // Run limit
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_24mhz);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Checking helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Mismatch %s: got %h expected %h (beat %0d)", name, got, expected,
                     beat_cnt);
            errors++;
        end
    endtask

    task automatic report_failure(input string text);
        $display("Error: %s", text);
        errors++;
    endtask

    // Row bit rule: brightness above the phase, phase below the lane limit
    function automatic logic [7:0] expected_rows(input bus_data_t word, input int phase);
        logic [7:0] rows;
        pixel_t     row_a;
        pixel_t     row_b;
        rows = '0;
        for (int g = 0; g < `ROW_GROUPS; g++) begin
            row_a = word[g*2*`PIXEL_BITS +: `PIXEL_BITS];
            row_b = word[g*2*`PIXEL_BITS + `PIXEL_BITS +: `PIXEL_BITS];
            rows[2*g]   = (row_a > phase) && (phase < lane_limit[g]);
            rows[2*g+1] = (row_b > phase) && (phase < lane_limit[g]);
        end
        return rows;
    endfunction

    // --------------------------------------------------
    // Pin monitor
    // --------------------------------------------------
    always @(negedge clk_24mhz) begin : pin_monitor
        int column;
        int bank;
        int phase;
        if (cycles > 0 && !started) begin
            if (col_advance_o && !rst_i) begin
                started = 1'b1;
                beat_cnt = 0;
            end else begin
                check_value("row_oe_n_o", row_oe_n_o, 1);
                check_value("col_advance_o", col_advance_o, 0);
                check_value("col_first_o", col_first_o, 0);
                check_value("rclk_o", rclk_o, 0);
                check_value("frame_complete_o", frame_complete_o, 0);
                check_value("latch_row_bank_o", latch_row_bank_o, 0);
                idle_checks++;
            end
        end
        if (started) begin
            check_value("rclk_o", rclk_o, rclk_due);
            if (col_advance_o) begin
                column = beat_cnt % `MATRIX_COLUMNS;
                bank   = (beat_cnt / `MATRIX_COLUMNS) % `MATRIX_BANKS;
                phase  = beat_cnt / FRAME_WORDS;
                check_value("col_first_o", col_first_o, column == 0);
                check_value("row_oe_n_o", row_oe_n_o, column == 0);
                check_value("latch_row_bank_o", latch_row_bank_o, 1 << bank);
                check_value("frame_complete_o", frame_complete_o, beat_cnt == FRAME_BEATS - 1);
                if (skip_beats > 0) begin
                    skip_beats--;
                end else begin
                    check_value("row_data_o", row_data_o,
                                expected_rows(shadow_frame[bank*`MATRIX_COLUMNS + column], phase));
                    checked_beats++;
                    // Lanes past their limit must be dark
                    for (int g = 0; g < `ROW_GROUPS; g++) begin
                        if (phase >= lane_limit[g]) begin
                            assert (row_data_o[2*g +: 2] == 2'b00) else begin
                                $display("Mismatch row_data_o lane %0d: got %h expected 0",
                                         g, row_data_o[2*g +: 2]);
                                errors++;
                            end
                            dark_checks++;
                        end
                    end
                end
                rclk_due = (column == `MATRIX_COLUMNS - 1);
                if (frame_complete_o || beat_cnt == FRAME_BEATS - 1) begin
                    if (frame_complete_o) begin
                        frames_seen++;
                    end
                    beat_cnt = 0;
                end else begin
                    beat_cnt++;
                end
            end else begin
                check_value("col_first_o", col_first_o, 0);
                check_value("frame_complete_o", frame_complete_o, 0);
                check_value("row_oe_n_o", row_oe_n_o, 0);
                rclk_due = 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Host port
    // --------------------------------------------------
    task automatic write_word(input int addr, input bus_data_t data);
        host_req_i.wr_stb = 1'b1;
        host_req_i.addr   = bus_addr_t'(addr);
        host_req_i.wdata  = data;
        if (addr & LIMIT_BASE) begin
            lane_limit[addr % `ROW_GROUPS] = data[`PIXEL_BITS-1:0];
        end else begin
            shadow_frame[addr % FRAME_WORDS] = data;
        end
        skip_beats = SKIP_BEATS;
        @(negedge clk_24mhz);
        host_req_i.wr_stb = 1'b0;
        // No read strobe in the write cycle
        check_value("rd_valid_o", rd_valid_o, 0);
    endtask

    task automatic read_check(input int addr, input bus_data_t expected);
        host_req_i.rd_stb = 1'b1;
        host_req_i.addr   = bus_addr_t'(addr);
        @(negedge clk_24mhz);
        host_req_i.rd_stb = 1'b0;
        check_value("rd_valid_o", rd_valid_o, 1);
        check_value("rd_data_o", rd_data_o, expected);
    endtask

    task automatic wait_frame_end();
        int seen;
        seen = frames_seen;
        while (frames_seen == seen) @(negedge clk_24mhz);
    endtask

    task automatic finish_test(input string name, input int errors_before, input bit reached);
        if (!reached) begin
            report_failure({"stimulus did not reach the checks of ", name});
        end
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic reset_and_idle();
        int err0;
        err0 = errors;
        repeat (10) @(negedge clk_24mhz);
        rst_i = 1'b0;
        while (!started) @(negedge clk_24mhz);
        finish_test("reset_and_idle", err0, idle_checks >= 10);
    endtask

    task automatic frame_readback();
        int err0;
        err0 = errors;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            write_word(i, $urandom);
        end
        for (int i = 0; i < FRAME_WORDS; i++) begin
            read_check(i, shadow_frame[i]);
        end
        finish_test("frame_readback", err0, 1'b1);
    endtask

    task automatic scan_full_frame();
        int err0;
        int checked0;
        err0 = errors;
        wait_frame_end();
        checked0 = checked_beats;
        wait_frame_end();
        finish_test("scan_full_frame", err0, checked_beats - checked0 == FRAME_BEATS);
    endtask

    task automatic lane_limit_sweep();
        int        err0;
        int        dark0;
        bus_data_t data;
        err0  = errors;
        dark0 = dark_checks;
        for (int g = 0; g < `ROW_GROUPS; g++) begin
            data = $urandom;
            data[`PIXEL_BITS-1:0] = pixel_t'(1 + $urandom % 14);
            write_word(LIMIT_BASE + g, data);
        end
        // Limit registers read back as zero
        read_check(LIMIT_BASE, '0);
        for (int i = 0; i < FRAME_WORDS; i++) begin
            read_check(i, shadow_frame[i]);
        end
        wait_frame_end();
        wait_frame_end();
        finish_test("lane_limit_sweep", err0, dark_checks > dark0);
    endtask

    initial begin : main
        int seed;
        seed = 15;
        void'($urandom(seed));
        rst_i      = 1'b1;
        host_req_i = '0;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            shadow_frame[i] = '0;
        end
        for (int g = 0; g < `ROW_GROUPS; g++) begin
            lane_limit[g] = '1;
        end

        reset_and_idle();
        frame_readback();
        scan_full_frame();
        lane_limit_sweep();

        $display("tests run %0d, passed %0d, failed %0d, checked beats %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, checked_beats, errors);
        if (errors == 0 && tests_passed == tests_run) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+logic
logic/matrix_pkg.sv
logic/scan_sequencer.sv
logic/frame_store.sv
logic/row_pwm_lane.sv
logic/row_latch.sv
logic/led_matrix_top.sv
tests/tb_led_matrix.sv
